// ==== hdl/lane_seq_pkg.sv ====
// Sizes, encodings and packed structs shared by the lane sequencer blocks
// Every RTL block and the testbench import this package with a wildcard import
`default_nettype none

package lane_seq_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  // Instruction IDs that can be in flight at the same time
  localparam int unsigned NrVInsn = 8;

  // One command slot per operand queue of the lane
  localparam int unsigned NrOperandQueues = 6;

  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  typedef logic [15:0]                vlen_t;
  typedef logic [4:0]                 vreg_t;

  // The mask operand always lives in v0
  localparam vreg_t VMaskReg = 5'd0;

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {EW8, EW16, EW32, EW64} ew_e;

  typedef enum logic [1:0] {VfuNone, VfuAlu, VfuMfpu} vfu_e;

  typedef enum logic [3:0] {
    VADD, VSUB, VAND, VMUL, VMACC, VFADD, VFMUL, VFMACC
  } vop_e;

  // Index into the operand command arrays
  typedef enum logic [2:0] {
    OpqAluA, OpqAluB, OpqMfpuA, OpqMfpuB, OpqMfpuC, OpqMaskM
  } opq_e;

  ////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////

  // Instruction as broadcast by the main sequencer to all lanes
  typedef struct packed {
    vid_t               id;
    vfu_e               vfu;
    vop_e               op;
    logic               vm;
    vreg_t              vs1;
    vreg_t              vs2;
    vreg_t              vd;
    ew_e                eew_vs1;
    ew_e                eew_vs2;
    ew_e                eew_vd;
    ew_e                vsew;
    logic               use_vs1;
    logic               use_vs2;
    logic               use_vd_op;
    logic               swap_vs2_vd;
    vlen_t              vl;
    vlen_t              vstart;
    logic [NrVInsn-1:0] hazard_vs1;
    logic [NrVInsn-1:0] hazard_vs2;
    logic [NrVInsn-1:0] hazard_vd;
    logic [NrVInsn-1:0] hazard_vm;
  } pe_req_t;

  // Fetch command for one operand queue
  typedef struct packed {
    vid_t               id;
    vreg_t              vs;
    ew_e                eew;
    vlen_t              vl;
    vlen_t              vstart;
    logic [NrVInsn-1:0] hazard;
  } operand_cmd_t;

  // Operation handed to the ALU or the MFPU of this lane
  typedef struct packed {
    vid_t  id;
    vfu_e  vfu;
    vop_e  op;
    logic  vm;
    vreg_t vd;
    ew_e   vsew;
    vlen_t vl;
    vlen_t vstart;
  } vfu_op_t;

  // This lane's share of the instruction lengths
  typedef struct packed {
    vlen_t vl;
    vlen_t vstart;
    vlen_t mask_vl;
  } lane_len_t;

endpackage

`default_nettype wire

// ==== hdl/req_intake.sv ====
// Intake of the broadcast instruction into one lane
// Holds one request in a fall-through register and takes each broadcast only once
`timescale 1ns/1ns
`default_nettype none

module req_intake import lane_seq_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  // Broadcast from the main sequencer
  input  pe_req_t pe_req_i,
  input  logic    pe_req_valid_i,
  output logic    pe_req_ready_o,
  // Held request towards the issue logic
  output pe_req_t req_o,
  output logic    req_valid_o,
  input  logic    req_ready_i
);

  // The lane split relies on a power-of-two lane count
  if ((NrLanes < 2) || (NrLanes > 16) || ((NrLanes & (NrLanes - 1)) != 0)) begin : gen_lanes_chk
    $error("NrLanes must be a power of two between 2 and 16");
  end

  vid_t    last_id_q;
  logic    sync_q;
  logic    in_valid;
  logic    in_xfer;
  logic    full_q;
  pe_req_t data_q;

  ////////////////////////////////////////////////////////////
  // Duplicate suppression
  ////////////////////////////////////////////////////////////

  // The main sequencer keeps the same instruction up until every lane took it,
  // so the id of the last transfer is masked until valid drops
  assign in_valid = pe_req_valid_i && !(sync_q && (pe_req_i.id == last_id_q));
  assign in_xfer  = in_valid && pe_req_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_id_q <= '0;
      sync_q    <= 1'b0;
    end else begin
      if (in_xfer) begin
        last_id_q <= pe_req_i.id;
        sync_q    <= 1'b1;
      end else if (!pe_req_valid_i) begin
        sync_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Fall-through register
  ////////////////////////////////////////////////////////////

  // When empty the incoming request passes straight on in the same cycle
  assign pe_req_ready_o = !full_q;
  assign req_valid_o    = full_q || in_valid;
  assign req_o          = full_q ? data_q : pe_req_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (in_xfer && !req_ready_i) begin
      full_q <= 1'b1;
    end else if (full_q && req_ready_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_xfer && !req_ready_i) begin
      data_q <= pe_req_i;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/lane_len_split.sv ====
// Share of the vector length, start index and mask length for one lane
// Purely combinational, evaluated on the request held by the intake
`timescale 1ns/1ns
`default_nettype none

module lane_len_split import lane_seq_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  input  logic [$clog2(NrLanes)-1:0] lane_id_i,
  input  pe_req_t                    req_i,
  output lane_len_t                  lane_len_o
);

  localparam int unsigned LaneIdxW = $clog2(NrLanes);

  vlen_t mask_words;
  vlen_t mask_back;

  always_comb begin
    // Elements are striped over the lanes, so the low lanes take the remainder
    lane_len_o.vl = req_i.vl >> LaneIdxW;
    if (lane_id_i < req_i.vl[LaneIdxW-1:0]) begin
      lane_len_o.vl = lane_len_o.vl + 16'd1;
    end

    lane_len_o.vstart = req_i.vstart >> LaneIdxW;
    if (lane_id_i < req_i.vstart[LaneIdxW-1:0]) begin
      lane_len_o.vstart = lane_len_o.vstart - 16'd1;
    end

    // Mask bits are packed eight per byte across all lanes and scaled by SEW
    mask_words = (req_i.vl >> (LaneIdxW + 3)) >> req_i.vsew;
    mask_back  = (mask_words << req_i.vsew) << (LaneIdxW + 3);

    // A partial mask word still has to be fetched
    lane_len_o.mask_vl = mask_words;
    if (mask_back != req_i.vl) begin
      lane_len_o.mask_vl = mask_words + 16'd1;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/operand_cmd_slots.sv ====
// Command slots towards the operand requester, one per operand queue
// A slot holds its command until the requester takes it
`timescale 1ns/1ns
`default_nettype none

module operand_cmd_slots import lane_seq_pkg::*; (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  // New commands from the issue logic
  input  logic         [NrOperandQueues-1:0] push_i,
  input  operand_cmd_t [NrOperandQueues-1:0] cmd_i,
  // Held commands towards the operand requester
  output operand_cmd_t [NrOperandQueues-1:0] cmd_o,
  output logic         [NrOperandQueues-1:0] valid_o,
  input  logic         [NrOperandQueues-1:0] ready_i
);

  // A push in the same cycle as the take overrides the clear
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_o <= '0;
    end else begin
      for (int unsigned q = 0; q < NrOperandQueues; q++) begin
        if (push_i[q]) begin
          valid_o[q] <= 1'b1;
        end else if (ready_i[q]) begin
          valid_o[q] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int unsigned q = 0; q < NrOperandQueues; q++) begin
      if (push_i[q]) begin
        cmd_o[q] <= cmd_i[q];
      end else if (ready_i[q]) begin
        cmd_o[q] <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/issue_ctrl.sv ====
// Issue logic of the lane sequencer: busy check, operand commands and unit operations
// Also keeps the running and done masks reported back to the main sequencer
`timescale 1ns/1ns
`default_nettype none

module issue_ctrl import lane_seq_pkg::*; (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  // Held request and its lane share
  input  pe_req_t                            req_i,
  input  logic                               req_valid_i,
  output logic                               req_ready_o,
  input  lane_len_t                          lane_len_i,
  // Operand command slots
  input  logic         [NrOperandQueues-1:0] slot_valid_i,
  output logic         [NrOperandQueues-1:0] push_o,
  output operand_cmd_t [NrOperandQueues-1:0] cmd_o,
  // Lane units
  output vfu_op_t                            vfu_op_o,
  output logic                               vfu_op_valid_o,
  input  logic         [NrVInsn-1:0]         alu_done_i,
  input  logic         [NrVInsn-1:0]         mfpu_done_i,
  // Main sequencer
  input  logic         [NrVInsn-1:0]         pe_vinsn_running_i,
  output logic         [NrVInsn-1:0]         pe_resp_o,
  output logic                               alu_done_o,
  output logic                               mfpu_done_o
);

  // Slots each unit must find free before it can take a request
  localparam logic [NrOperandQueues-1:0] AluSlots =
    NrOperandQueues'((1 << OpqAluA) | (1 << OpqAluB) | (1 << OpqMaskM));
  localparam logic [NrOperandQueues-1:0] MfpuSlots =
    NrOperandQueues'((1 << OpqMfpuA) | (1 << OpqMfpuB) | (1 << OpqMfpuC) | (1 << OpqMaskM));

  logic [NrVInsn-1:0] running_q, running_d, running_live;
  logic [NrVInsn-1:0] done_q, done_d;
  logic               slots_busy;
  logic               issue;
  logic               muted;
  vfu_op_t            vfu_op_d;
  logic               vfu_op_valid_d;
  operand_cmd_t       vs1_cmd, vs2_cmd, vd_cmd, mask_cmd;

  ////////////////////////////////////////////////////////////
  // Admission
  ////////////////////////////////////////////////////////////

  // A running bit only lives on while the main sequencer still tracks the id
  assign running_live = running_q & pe_vinsn_running_i;

  always_comb begin
    case (req_i.vfu)
      VfuAlu:  slots_busy = |(slot_valid_i & AluSlots);
      VfuMfpu: slots_busy = |(slot_valid_i & MfpuSlots);
      default: slots_busy = 1'b0;
    endcase
  end

  assign req_ready_o = !slots_busy && !running_live[req_i.id];
  assign issue       = req_valid_i && req_ready_o;
  assign muted       = (lane_len_i.vl == '0) && (req_i.vfu inside {VfuAlu, VfuMfpu});

  ////////////////////////////////////////////////////////////
  // Operand commands
  ////////////////////////////////////////////////////////////

  // Every operand also waits on writers of vd
  assign vs1_cmd = '{id: req_i.id, vs: req_i.vs1, eew: req_i.eew_vs1, vl: lane_len_i.vl,
                     vstart: lane_len_i.vstart, hazard: req_i.hazard_vs1 | req_i.hazard_vd};
  assign vs2_cmd = '{id: req_i.id, vs: req_i.vs2, eew: req_i.eew_vs2, vl: lane_len_i.vl,
                     vstart: lane_len_i.vstart, hazard: req_i.hazard_vs2 | req_i.hazard_vd};
  assign vd_cmd  = '{id: req_i.id, vs: req_i.vd, eew: req_i.eew_vd, vl: lane_len_i.vl,
                     vstart: lane_len_i.vstart, hazard: req_i.hazard_vd};
  assign mask_cmd = '{id: req_i.id, vs: VMaskReg, eew: req_i.vsew, vl: lane_len_i.mask_vl,
                      vstart: lane_len_i.vstart, hazard: req_i.hazard_vm | req_i.hazard_vd};

  always_comb begin
    cmd_o[OpqAluA]  = vs1_cmd;
    cmd_o[OpqAluB]  = vs2_cmd;
    cmd_o[OpqMfpuA] = vs1_cmd;
    // Multiply-add forms that accumulate into vs2 swap the B and C operands
    cmd_o[OpqMfpuB] = req_i.swap_vs2_vd ? vd_cmd : vs2_cmd;
    cmd_o[OpqMfpuC] = req_i.swap_vs2_vd ? vs2_cmd : vd_cmd;
    cmd_o[OpqMaskM] = mask_cmd;
  end

  ////////////////////////////////////////////////////////////
  // Issue and tracking
  ////////////////////////////////////////////////////////////

  always_comb begin
    running_d      = running_live;
    done_d         = alu_done_i | mfpu_done_i;
    push_o         = '0;
    vfu_op_valid_d = 1'b0;
    vfu_op_d       = '{id: req_i.id, vfu: req_i.vfu, op: req_i.op, vm: req_i.vm,
                       vd: req_i.vd, vsew: req_i.vsew, vl: lane_len_i.vl,
                       vstart: lane_len_i.vstart};

    if (issue) begin
      if (muted) begin
        // No elements land in this lane, so the instruction is finished here
        done_d[req_i.id] = 1'b1;
      end else if (req_i.vfu inside {VfuAlu, VfuMfpu}) begin
        vfu_op_valid_d      = 1'b1;
        running_d[req_i.id] = 1'b1;
        push_o[OpqMaskM]    = !req_i.vm;
        if (req_i.vfu == VfuAlu) begin
          push_o[OpqAluA] = req_i.use_vs1;
          push_o[OpqAluB] = req_i.use_vs2;
        end else begin
          push_o[OpqMfpuA] = req_i.use_vs1;
          push_o[OpqMfpuB] = req_i.swap_vs2_vd ? req_i.use_vd_op : req_i.use_vs2;
          push_o[OpqMfpuC] = req_i.swap_vs2_vd ? req_i.use_vs2 : req_i.use_vd_op;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q      <= '0;
      done_q         <= '0;
      vfu_op_valid_o <= 1'b0;
      alu_done_o     <= 1'b0;
      mfpu_done_o    <= 1'b0;
    end else begin
      running_q      <= running_d;
      done_q         <= done_d;
      vfu_op_valid_o <= vfu_op_valid_d;
      alu_done_o     <= |alu_done_i;
      mfpu_done_o    <= |mfpu_done_i;
    end
  end

  always_ff @(posedge clk_i) begin
    vfu_op_o <= vfu_op_d;
  end

  assign pe_resp_o = done_q;

endmodule

`default_nettype wire

// ==== hdl/lane_sequencer.sv ====
// Sequencer of one vector lane, top level of the design
// Connects the request intake, the lane split, the issue logic and the command slots
`timescale 1ns/1ns
`default_nettype none

module lane_sequencer import lane_seq_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic         [$clog2(NrLanes)-1:0] lane_id_i,
  // Main sequencer
  input  pe_req_t                            pe_req_i,
  input  logic                               pe_req_valid_i,
  output logic                               pe_req_ready_o,
  input  logic         [NrVInsn-1:0]         pe_vinsn_running_i,
  output logic         [NrVInsn-1:0]         pe_resp_o,
  // Operand requester
  output operand_cmd_t [NrOperandQueues-1:0] operand_cmd_o,
  output logic         [NrOperandQueues-1:0] operand_cmd_valid_o,
  input  logic         [NrOperandQueues-1:0] operand_cmd_ready_i,
  output logic                               alu_done_o,
  output logic                               mfpu_done_o,
  // Lane units
  output vfu_op_t                            vfu_op_o,
  output logic                               vfu_op_valid_o,
  input  logic         [NrVInsn-1:0]         alu_done_i,
  input  logic         [NrVInsn-1:0]         mfpu_done_i
);

  pe_req_t                            req;
  logic                               req_valid;
  logic                               req_ready;
  lane_len_t                          lane_len;
  logic         [NrOperandQueues-1:0] push;
  operand_cmd_t [NrOperandQueues-1:0] cmd_new;

  req_intake #(.NrLanes(NrLanes)) u_req_intake (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .pe_req_i      (pe_req_i),
    .pe_req_valid_i(pe_req_valid_i),
    .pe_req_ready_o(pe_req_ready_o),
    .req_o         (req),
    .req_valid_o   (req_valid),
    .req_ready_i   (req_ready)
  );

  lane_len_split #(.NrLanes(NrLanes)) u_lane_len_split (
    .lane_id_i (lane_id_i),
    .req_i     (req),
    .lane_len_o(lane_len)
  );

  issue_ctrl u_issue_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .req_i             (req),
    .req_valid_i       (req_valid),
    .req_ready_o       (req_ready),
    .lane_len_i        (lane_len),
    .slot_valid_i      (operand_cmd_valid_o),
    .push_o            (push),
    .cmd_o             (cmd_new),
    .vfu_op_o          (vfu_op_o),
    .vfu_op_valid_o    (vfu_op_valid_o),
    .alu_done_i        (alu_done_i),
    .mfpu_done_i       (mfpu_done_i),
    .pe_vinsn_running_i(pe_vinsn_running_i),
    .pe_resp_o         (pe_resp_o),
    .alu_done_o        (alu_done_o),
    .mfpu_done_o       (mfpu_done_o)
  );

  operand_cmd_slots u_operand_cmd_slots (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (push),
    .cmd_i  (cmd_new),
    .cmd_o  (operand_cmd_o),
    .valid_o(operand_cmd_valid_o),
    .ready_i(operand_cmd_ready_i)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_ref_model.svh ====
// Reference model of the lane sequencer, included inside the testbench module
// Computes the lane share, the operand commands and the unit operation of a request
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Entry of the queue of expected operand commands
typedef struct packed {
  opq_e         opq;
  operand_cmd_t cmd;
} exp_cmd_t;

function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

function automatic lane_len_t split_lengths(input int unsigned lane, input pe_req_t req);
  lane_len_t   len;
  int unsigned words;
  len.vl     = vlen_t'(req.vl / NrLanes + ((lane < req.vl % NrLanes) ? 1 : 0));
  len.vstart = vlen_t'(req.vstart / NrLanes - ((lane < req.vstart % NrLanes) ? 1 : 0));
  // Eight mask bits per byte over all lanes, scaled down by the element width
  words       = (req.vl / (NrLanes * 8)) >> req.vsew;
  len.mask_vl = vlen_t'(words + ((((words << req.vsew) * NrLanes * 8) != req.vl) ? 1 : 0));
  return len;
endfunction

// A unit operation only leaves the lane when some elements land here
function automatic logic lane_gets_op(input pe_req_t req, input lane_len_t len);
  return (req.vfu inside {VfuAlu, VfuMfpu}) && (len.vl != 0);
endfunction

function automatic logic [NrOperandQueues-1:0] queues_pushed(input pe_req_t req,
                                                             input lane_len_t len);
  logic [NrOperandQueues-1:0] push;
  push = '0;
  if (lane_gets_op(req, len)) begin
    push[OpqMaskM] = !req.vm;
    if (req.vfu == VfuAlu) begin
      push[OpqAluA] = req.use_vs1;
      push[OpqAluB] = req.use_vs2;
    end else begin
      push[OpqMfpuA] = req.use_vs1;
      push[OpqMfpuB] = req.swap_vs2_vd ? req.use_vd_op : req.use_vs2;
      push[OpqMfpuC] = req.swap_vs2_vd ? req.use_vs2 : req.use_vd_op;
    end
  end
  return push;
endfunction

// Sources and the mask also wait on earlier writers of vd
function automatic operand_cmd_t queue_command(input opq_e q, input pe_req_t req,
                                               input lane_len_t len);
  operand_cmd_t cmd;
  logic         is_vs2;
  is_vs2 = (q == OpqAluB) || ((q == OpqMfpuB) && !req.swap_vs2_vd) ||
           ((q == OpqMfpuC) && req.swap_vs2_vd);
  cmd = '{id: req.id, vs: req.vd, eew: req.eew_vd, vl: len.vl, vstart: len.vstart,
          hazard: req.hazard_vd};
  if (q inside {OpqAluA, OpqMfpuA}) begin
    cmd.vs     = req.vs1;
    cmd.eew    = req.eew_vs1;
    cmd.hazard = req.hazard_vs1 | req.hazard_vd;
  end else if (is_vs2) begin
    cmd.vs     = req.vs2;
    cmd.eew    = req.eew_vs2;
    cmd.hazard = req.hazard_vs2 | req.hazard_vd;
  end else if (q == OpqMaskM) begin
    cmd.vs     = VMaskReg;
    cmd.eew    = req.vsew;
    cmd.vl     = len.mask_vl;
    cmd.hazard = req.hazard_vm | req.hazard_vd;
  end
  return cmd;
endfunction

function automatic vfu_op_t unit_operation(input pe_req_t req, input lane_len_t len);
  return '{id: req.id, vfu: req.vfu, op: req.op, vm: req.vm, vd: req.vd, vsew: req.vsew,
           vl: len.vl, vstart: len.vstart};
endfunction

`endif

// ==== testbench/tb_lane_sequencer.sv ====
// Testbench of the lane sequencer
// Drives broadcast requests and done masks, and checks the lane outputs against a model
`timescale 1ns/1ns
`default_nettype none

module tb_lane_sequencer import lane_seq_pkg::*; ();

  localparam int unsigned NrLanes   = 4;
  localparam int unsigned LaneIdW   = $clog2(NrLanes);
  localparam int unsigned WaitLimit = 200;

  logic                               clk;
  logic                               rst_n;
  logic         [LaneIdW-1:0]         lane_id;
  pe_req_t                            pe_req;
  logic                               pe_req_valid;
  logic                               pe_req_ready;
  logic         [NrVInsn-1:0]         pe_vinsn_running;
  logic         [NrVInsn-1:0]         pe_resp;
  operand_cmd_t [NrOperandQueues-1:0] operand_cmd;
  logic         [NrOperandQueues-1:0] operand_cmd_valid;
  logic         [NrOperandQueues-1:0] operand_cmd_ready;
  logic                               alu_done;
  logic                               mfpu_done;
  vfu_op_t                            vfu_op;
  logic                               vfu_op_valid;
  logic         [NrVInsn-1:0]         alu_done_in;
  logic         [NrVInsn-1:0]         mfpu_done_in;

  `include "tb_ref_model.svh"

  vfu_op_t                    exp_op_q[$];
  exp_cmd_t                   exp_cmd_q[$];
  int unsigned                errors;
  int unsigned                checks;
  int unsigned                ops_seen;
  logic [31:0]                rng_state;
  logic [NrOperandQueues-1:0] valid_prev;

  lane_sequencer #(.NrLanes(NrLanes)) dut (
    .clk_i              (clk),
    .rst_ni             (rst_n),
    .lane_id_i          (lane_id),
    .pe_req_i           (pe_req),
    .pe_req_valid_i     (pe_req_valid),
    .pe_req_ready_o     (pe_req_ready),
    .pe_vinsn_running_i (pe_vinsn_running),
    .pe_resp_o          (pe_resp),
    .operand_cmd_o      (operand_cmd),
    .operand_cmd_valid_o(operand_cmd_valid),
    .operand_cmd_ready_i(operand_cmd_ready),
    .alu_done_o         (alu_done),
    .mfpu_done_o        (mfpu_done),
    .vfu_op_o           (vfu_op),
    .vfu_op_valid_o     (vfu_op_valid),
    .alu_done_i         (alu_done_in),
    .mfpu_done_i        (mfpu_done_in)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Checking on the falling edge, where all outputs are settled
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    vfu_op_t  exp_op;
    exp_cmd_t exp_c;
    if (rst_n) begin
      if (vfu_op_valid) begin
        ops_seen++;
        if (exp_op_q.size() == 0) begin
          errors++;
          $display("unexpected unit operation with id %0d at %0t ns", vfu_op.id, $time);
        end else begin
          exp_op = exp_op_q.pop_front();
          checks++;
          if (vfu_op !== exp_op) begin
            errors++;
            $display("mismatch at %0t ns: vfu_op_o expected %h got %h", $time, exp_op, vfu_op);
          end
        end
      end
      // A slot that turns valid carries a freshly pushed command
      for (int q = 0; q < NrOperandQueues; q++) begin
        if (operand_cmd_valid[q] && !valid_prev[q]) begin
          if (exp_cmd_q.size() == 0) begin
            errors++;
            $display("unexpected operand command on queue %0d at %0t ns", q, $time);
          end else begin
            exp_c = exp_cmd_q.pop_front();
            checks++;
            if (exp_c.opq != q) begin
              errors++;
              $display("operand command appeared on queue %0d instead of queue %0d at %0t ns",
                       q, exp_c.opq, $time);
            end else if (operand_cmd[q] !== exp_c.cmd) begin
              errors++;
              $display("mismatch at %0t ns: operand_cmd_o[%0d] expected %h got %h",
                       $time, q, exp_c.cmd, operand_cmd[q]);
            end
          end
        end
      end
    end
    valid_prev = operand_cmd_valid;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] rand_word();
    rng_state = lcg_next(rng_state);
    return rng_state;
  endfunction

  task automatic make_req(input vfu_e vfu, output pe_req_t req);
    logic [31:0] w0;
    logic [31:0] w1;
    logic [31:0] w2;
    w0 = rand_word();
    w1 = rand_word();
    w2 = rand_word();
    req             = '0;
    req.id          = w0[31:29];
    req.vfu         = vfu;
    req.op          = vop_e'({1'b0, w0[28:26]});
    req.vm          = w0[25];
    req.vs1         = w0[24:20];
    req.vs2         = w0[19:15];
    req.vd          = w0[14:10];
    req.eew_vs1     = ew_e'(w0[9:8]);
    req.eew_vs2     = ew_e'(w0[7:6]);
    req.eew_vd      = ew_e'(w0[5:4]);
    req.vsew        = ew_e'(w0[3:2]);
    req.use_vs1     = w1[29];
    req.use_vs2     = w1[28];
    req.use_vd_op   = w1[31];
    req.swap_vs2_vd = w1[30];
    // Up to 512 elements, start index below 64
    req.vl          = vlen_t'(w1[24:16]) + 16'd1;
    req.vstart      = vlen_t'(w1[5:0]);
    req.hazard_vs1  = w2[31:24];
    req.hazard_vs2  = w2[23:16];
    req.hazard_vd   = w2[15:8];
    req.hazard_vm   = w1[15:8];
  endtask

  task automatic expect_issue(input pe_req_t req);
    lane_len_t                  len;
    logic [NrOperandQueues-1:0] push;
    exp_cmd_t                   entry;
    len  = split_lengths(lane_id, req);
    push = queues_pushed(req, len);
    if (lane_gets_op(req, len)) begin
      exp_op_q.push_back(unit_operation(req, len));
    end
    for (int q = 0; q < NrOperandQueues; q++) begin
      if (push[q]) begin
        entry.opq = opq_e'(q);
        entry.cmd = queue_command(opq_e'(q), req, len);
        exp_cmd_q.push_back(entry);
      end
    end
  endtask

  // Returns right after the edge on which the request is taken
  task automatic send_req(input pe_req_t req);
    int unsigned n;
    @(posedge clk);
    expect_issue(req);
    pe_req       <= req;
    pe_req_valid <= 1'b1;
    n = 0;
    @(negedge clk);
    while (!pe_req_ready && n < WaitLimit) begin
      @(negedge clk);
      n++;
    end
    if (!pe_req_ready) begin
      errors++;
      $display("timeout: request with id %0d was never accepted", req.id);
    end
    @(posedge clk);
    pe_req_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    int unsigned n;
    n = 0;
    while ((exp_op_q.size() != 0 || exp_cmd_q.size() != 0) && n < WaitLimit) begin
      @(negedge clk);
      n++;
    end
    if (exp_op_q.size() != 0 || exp_cmd_q.size() != 0) begin
      errors++;
      $display("timeout: %0d unit operations and %0d operand commands never appeared",
               exp_op_q.size(), exp_cmd_q.size());
      exp_op_q.delete();
      exp_cmd_q.delete();
    end
  endtask

  task automatic report_test(input string name, input int unsigned errors_before);
    $display("test %s finished with %0d failures", name, errors - errors_before);
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    pe_req_t     req;
    logic [31:0] w;
    int unsigned err_start;
    int unsigned ops_before;
    int unsigned vl;
    int unsigned n;
    clk               = 1'b0;
    rst_n             = 1'b0;
    lane_id           = '0;
    pe_req            = '0;
    pe_req_valid      = 1'b0;
    pe_vinsn_running  = '0;
    operand_cmd_ready = '1;
    alu_done_in       = '0;
    mfpu_done_in      = '0;
    rng_state         = 32'h8290cf39;
    errors            = 0;
    checks            = 0;
    ops_seen          = 0;
    valid_prev        = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    err_start = errors;
    for (int i = 0; i < 24; i++) begin
      w = rand_word();
      @(posedge clk);
      lane_id <= w[LaneIdW+7:8];
      make_req(VfuAlu, req);
      req.use_vs1 = 1'b1;
      req.use_vs2 = 1'b1;
      send_req(req);
      wait_drain();
    end
    report_test("alu_split", err_start);

    err_start = errors;
    for (int i = 0; i < 16; i++) begin
      w = rand_word();
      @(posedge clk);
      lane_id <= w[LaneIdW+7:8];
      make_req(VfuMfpu, req);
      req.swap_vs2_vd = i[0];
      if (i < 8) begin
        req.use_vs1   = 1'b1;
        req.use_vs2   = 1'b1;
        req.use_vd_op = 1'b1;
      end
      send_req(req);
      wait_drain();
    end
    report_test("mfpu_routing", err_start);

    // The same broadcast stays valid for many cycles
    err_start = errors;
    make_req(VfuAlu, req);
    req.vl     = 16'd64;
    ops_before = ops_seen;
    @(posedge clk);
    expect_issue(req);
    pe_req       <= req;
    pe_req_valid <= 1'b1;
    repeat (20) @(posedge clk);
    pe_req_valid <= 1'b0;
    wait_drain();
    checks++;
    if (ops_seen - ops_before != 1) begin
      errors++;
      $display("a repeated broadcast issued %0d unit operations", ops_seen - ops_before);
    end
    report_test("duplicate_suppression", err_start);

    err_start = errors;
    @(posedge clk);
    operand_cmd_ready <= '0;
    make_req(VfuAlu, req);
    req.use_vs1 = 1'b1;
    req.vl      = 16'd100;
    send_req(req);
    wait_drain();
    make_req(VfuAlu, req);
    req.id     = req.id + 3'd1;
    req.vl     = 16'd37;
    ops_before = ops_seen;
    send_req(req);
    repeat (10) begin
      @(negedge clk);
      checks++;
      if (pe_req_ready || ops_seen != ops_before) begin
        errors++;
        $display("request behind a busy slot was not held back at %0t ns", $time);
      end
    end
    @(posedge clk);
    operand_cmd_ready <= '1;
    wait_drain();
    if (ops_seen - ops_before != 1) begin
      errors++;
      $display("held request did not issue once after the slots were freed");
    end
    report_test("back_pressure", err_start);

    // Fewer elements than lanes, so the upper lanes get nothing
    err_start = errors;
    for (int i = 0; i < 6; i++) begin
      w  = rand_word();
      vl = 1 + w[23:16] % (NrLanes - 1);
      @(posedge clk);
      lane_id <= LaneIdW'(vl + w[31:24] % (NrLanes - vl));
      make_req(i[0] ? VfuMfpu : VfuAlu, req);
      req.vl     = vlen_t'(vl);
      ops_before = ops_seen;
      send_req(req);
      n = 0;
      @(negedge clk);
      while (!pe_resp[req.id] && n < WaitLimit) begin
        @(negedge clk);
        n++;
      end
      checks++;
      if (!pe_resp[req.id]) begin
        errors++;
        $display("timeout: zero length request with id %0d never reported done", req.id);
      end
      repeat (4) @(negedge clk);
      if (ops_seen != ops_before) begin
        errors++;
        $display("zero length request with id %0d issued a unit operation", req.id);
      end
    end
    report_test("zero_length", err_start);

    err_start = errors;
    for (int i = 0; i < 8; i++) begin
      w = rand_word();
      @(posedge clk);
      alu_done_in  <= w[16] ? w[31:24] : 8'h00;
      mfpu_done_in <= w[17] ? w[23:16] : 8'h00;
      @(posedge clk);
      alu_done_in  <= '0;
      mfpu_done_in <= '0;
      @(negedge clk);
      checks++;
      if (pe_resp !== ((w[16] ? w[31:24] : 8'h00) | (w[17] ? w[23:16] : 8'h00))) begin
        errors++;
        $display("mismatch at %0t ns: pe_resp_o expected %h got %h", $time,
                 (w[16] ? w[31:24] : 8'h00) | (w[17] ? w[23:16] : 8'h00), pe_resp);
      end
      if (alu_done !== (w[16] && (w[31:24] != 0)) ||
          mfpu_done !== (w[17] && (w[23:16] != 0))) begin
        errors++;
        $display("mismatch at %0t ns: alu_done_o/mfpu_done_o expected %b%b got %b%b", $time,
                 w[16] && (w[31:24] != 0), w[17] && (w[23:16] != 0), alu_done, mfpu_done);
      end
    end
    report_test("done_forwarding", err_start);

    wait_drain();
    $display("%0d checks, %0d failures", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+testbench
hdl/lane_seq_pkg.sv
hdl/req_intake.sv
hdl/lane_len_split.sv
hdl/operand_cmd_slots.sv
hdl/issue_ctrl.sv
hdl/lane_sequencer.sv
testbench/tb_lane_sequencer.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the lane sequencer testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_lane_sequencer -f src.f -o sim_lane
./obj_dir/sim_lane | tee sim.log

if grep -qx "No errors" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
